//--- bench/lsu_testdata.txt
# name cls mt dest off csr_we csr_re csr_num pc rj rkd mask exp kind (all hex)
# kind 0 plain commit, 1 syscall flush, 2 ertn flush, 3 killed by the flush ahead of it
st_w    2 0 00 000 0 0 0000 1c000000 00000100 11223344 00000000 00000000 0
st_h    2 1 00 002 0 0 0000 1c000004 00000100 0000beef 00000000 00000000 0
st_b    2 2 00 001 0 0 0000 1c000008 00000100 0000005a 00000000 00000000 0
ld_w    1 0 04 000 0 0 0000 1c00000c 00000100 00000000 00000000 beef5a44 0
ld_h2   1 1 05 002 0 0 0000 1c000010 00000100 00000000 00000000 ffffbeef 0
ld_hu2  1 5 06 002 0 0 0000 1c000014 00000100 00000000 00000000 0000beef 0
ld_h0   1 1 07 000 0 0 0000 1c000018 00000100 00000000 00000000 00005a44 0
ld_b2   1 2 08 002 0 0 0000 1c00001c 00000100 00000000 00000000 ffffffef 0
ld_b3   1 2 09 fff 0 0 0000 1c000020 00000104 00000000 00000000 ffffffbe 0
ld_bu3  1 6 0a 003 0 0 0000 1c000024 00000100 00000000 00000000 000000be 0
ld_bu1  1 6 0b 001 0 0 0000 1c000028 00000100 00000000 00000000 0000005a 0
ld_b0   1 2 0c 000 0 0 0000 1c00002c 00000100 00000000 00000000 00000044 0
csr_wr  3 0 0d 000 1 1 0002 1c000030 00000000 aaaa5555 0000ffff 00000000 0
csr_rd  3 0 0e 000 0 1 0002 1c000034 00000000 00000000 00000000 00005555 0
csr_wr2 3 0 0f 000 1 1 000a 1c000038 00000000 12345678 ffff0000 00005555 0
csr_rd2 3 0 10 000 0 1 0002 1c00003c 00000000 00000000 00000000 12345555 0
alu     0 0 11 000 0 0 0000 1c000040 cafef00d 00000000 00000000 cafef00d 0
sys     4 0 00 000 0 0 0000 1c000100 00000000 00000000 00000000 00000000 1
k_st    2 0 00 000 0 0 0000 1c000104 00000100 deaddead 00000000 00000000 3
k_alu   0 0 12 000 0 0 0000 1c000108 00000001 00000000 00000000 00000001 3
ld_chk  1 0 13 ff8 0 0 0000 1c000200 00000108 00000000 00000000 beef5a44 0
era_rd  3 0 14 000 0 1 0006 1c000204 00000000 00000000 00000000 1c000100 0
ertn    5 0 00 000 0 0 0000 1c000208 00000000 00000000 00000000 1c000100 2
k_alu2  0 0 15 000 0 0 0000 1c00020c 00000002 00000000 00000000 00000002 3
k_alu3  0 0 16 000 0 0 0000 1c000210 00000003 00000000 00000000 00000003 3
ld_end  1 0 17 000 0 0 0000 1c000100 00000100 00000000 00000000 beef5a44 0

//--- project.f
logic/lsu_pkg.sv
logic/data_sram.sv
logic/ex_stage.sv
logic/mem_stage.sv
logic/wb_stage.sv
logic/lsu_top.sv
bench/lsu_asserts.sv
bench/lsu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= lsu_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= project.f
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/lsu_tb.sv
module lsu_tb import lsu_pkg::*; ();

    logic        clk;
    logic        resetn;
    logic        issue_valid;
    issue_word_u issue_word;
    logic [31:0] issue_pc;
    logic [31:0] issue_inst;
    logic [31:0] rj_value;
    logic [31:0] rkd_value;
    logic [31:0] csr_wmask;
    logic        issue_allowin;
    logic        fwd_valid;
    logic [4:0]  fwd_dest;
    logic [31:0] fwd_data;
    logic        fwd_csr;
    logic [13:0] fwd_csr_num;
    logic        commit_valid;
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;
    logic [31:0] commit_pc;
    logic        commit_ready;
    logic        ex_flush;
    logic [31:0] ex_era;
    logic        ertn_flush;
    logic [31:0] ertn_era;

    logic [8*12-1:0] name_a [64];
    logic [2:0]      cls_a  [64];
    logic [2:0]      mt_a   [64];
    logic [4:0]      dest_a [64];
    logic [11:0]     off_a  [64];
    logic            we_a   [64];
    logic            re_a   [64];
    logic [13:0]     num_a  [64];
    logic [31:0]     pc_a   [64];
    logic [31:0]     rj_a   [64];
    logic [31:0]     rkd_a  [64];
    logic [31:0]     mask_a [64];
    logic [31:0]     exp_a  [64];
    logic [1:0]      kind_a [64];

    int n_ops;
    int idx;
    int ci;
    int errors;
    int n_commit;
    int n_exp;
    int exp_q[$];
    int infl_q[$]; // accepted ops still in the pipeline, oldest first

    lsu_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check(input logic [8*12-1:0] name, input string field,
                         input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %0s %0s: expected %h, actual %h", name, field, expected, actual);
            errors++;
        end
    endtask

    function automatic logic [31:0] build_word(int i);
        if (cls_a[i] == op_csr) begin
            return {cls_a[i], we_a[i], re_a[i], num_a[i], dest_a[i], 8'd0};
        end
        return {cls_a[i], mt_a[i], dest_a[i], off_a[i], 9'd0};
    endfunction

    // alu, loads and csr reads write the register file
    function automatic logic writes_rf(int i);
        return cls_a[i] == op_alu || cls_a[i] == op_load || (cls_a[i] == op_csr && re_a[i]);
    endfunction

    task automatic read_ops();
        int    fd;
        int    code;
        string line;
        fd = $fopen("bench/lsu_testdata.txt", "r");
        if (fd == 0) begin
            $display("Cannot open bench/lsu_testdata.txt");
            errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            code = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h",
                name_a[n_ops], cls_a[n_ops], mt_a[n_ops], dest_a[n_ops], off_a[n_ops],
                we_a[n_ops], re_a[n_ops], num_a[n_ops], pc_a[n_ops], rj_a[n_ops],
                rkd_a[n_ops], mask_a[n_ops], exp_a[n_ops], kind_a[n_ops]);
            if (code == 14) begin
                if (kind_a[n_ops] != 2'd3) begin
                    exp_q.push_back(n_ops);
                end
                n_ops++;
            end
        end
        $fclose(fd);
        n_exp = exp_q.size();
    endtask

    // killed ops go in back to back so they sit right behind the flush
    task automatic drive_issue();
        if (issue_valid && issue_allowin) begin
            infl_q.push_back(idx);
            idx++;
        end
        if (idx < n_ops) begin
            issue_valid <= kind_a[idx] == 2'd3 || ($urandom % 4) != 0;
            issue_word  <= build_word(idx);
            issue_pc    <= pc_a[idx];
            issue_inst  <= build_word(idx);
            rj_value    <= rj_a[idx];
            rkd_value   <= rkd_a[idx];
            csr_wmask   <= mask_a[idx];
        end else begin
            issue_valid <= 1'b0;
        end
        commit_ready <= ($urandom % 4) != 0;
    endtask

    // mem holds the oldest op that has not reached wb
    task automatic check_forwarding();
        int pos;
        int fi;
        pos = commit_valid ? 1 : 0;
        if (fwd_valid || fwd_csr) begin
            if (infl_q.size() <= pos) begin
                $display("Forwarding active with no operation left in the memory stage");
                errors++;
            end else begin
                fi = infl_q[pos];
                check(name_a[fi], "fwd_valid", 32'(writes_rf(fi)), 32'(fwd_valid));
                check(name_a[fi], "fwd_csr",
                      32'(cls_a[fi] == op_csr && (we_a[fi] || re_a[fi])), 32'(fwd_csr));
                if (fwd_valid) begin
                    check(name_a[fi], "fwd_dest", 32'(dest_a[fi]), 32'(fwd_dest));
                end
                if (fwd_valid && cls_a[fi] != op_csr) begin
                    check(name_a[fi], "fwd_data", exp_a[fi], fwd_data); // csr data comes in wb
                end
                if (fwd_csr) begin
                    check(name_a[fi], "fwd_csr_num", 32'(num_a[fi]), 32'(fwd_csr_num));
                end
            end
        end
    endtask

    initial begin
        void'($urandom(32'hbd62_3f41));
        resetn       = 1'b0;
        issue_valid  = 1'b0;
        issue_word   = '0;
        issue_pc     = 32'd0;
        issue_inst   = 32'd0;
        rj_value     = 32'd0;
        rkd_value    = 32'd0;
        csr_wmask    = 32'd0;
        commit_ready = 1'b0;
        read_ops();
        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        while (idx < n_ops || exp_q.size() != 0) begin
            @(posedge clk);
            drive_issue();
        end
        commit_ready <= 1'b1;
        repeat (10) @(posedge clk); // catch stray commits
        $display("errors: %0d, assertion failures: %0d, commits: %0d of %0d",
                 errors, dut0.u_asserts.fail_count, n_commit, n_exp);
        if (errors == 0 && dut0.u_asserts.fail_count == 0 && n_commit == n_exp) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    always @(posedge clk) begin
        if (resetn) begin
            check_forwarding();
        end
        if (resetn && commit_valid && commit_ready) begin
            if (infl_q.size() != 0) begin
                void'(infl_q.pop_front());
            end
            if (exp_q.size() == 0) begin
                $display("Unexpected commit at pc %h after all expected commits", commit_pc);
                errors++;
            end else begin
                ci = exp_q.pop_front();
                n_commit++;
                check(name_a[ci], "pc", pc_a[ci], commit_pc);
                check(name_a[ci], "rf_we", 32'(writes_rf(ci)), 32'(rf_we));
                if (writes_rf(ci)) begin
                    check(name_a[ci], "rf_waddr", 32'(dest_a[ci]), 32'(rf_waddr));
                    check(name_a[ci], "rf_wdata", exp_a[ci], rf_wdata);
                end
                check(name_a[ci], "ex_flush", 32'(kind_a[ci] == 2'd1), 32'(ex_flush));
                check(name_a[ci], "ertn_flush", 32'(kind_a[ci] == 2'd2), 32'(ertn_flush));
                if (kind_a[ci] == 2'd1) begin
                    check(name_a[ci], "ex_era", pc_a[ci], ex_era);
                end
                if (kind_a[ci] == 2'd2) begin
                    check(name_a[ci], "ertn_era", exp_a[ci], ertn_era);
                end
                if (kind_a[ci] == 2'd1 || kind_a[ci] == 2'd2) begin
                    infl_q.delete(); // younger ops die in the flush
                end
            end
        end
    end

    initial begin
        #1;
        repeat (n_ops * 40 + 20) @(posedge clk);
        $display("Timeout: %0d of %0d commits seen before the cycle limit", n_commit, n_exp);
        $display("Verification failed");
        $finish;
    end

endmodule

//--- bench/lsu_asserts.sv
module lsu_asserts (
    input logic        clk,
    input logic        resetn,
    input logic        mem_ex,
    input logic [3:0]  data_sram_we,
    input logic        commit_valid,
    input logic        commit_ready,
    input logic [31:0] commit_pc,
    input logic        ex_flush,
    input logic        ertn_flush
);

    int fail_count;

    // a syscall in mem blocks any store leaving ex
    a_no_store_on_ex: assert property (@(posedge clk) disable iff (!resetn)
        mem_ex |-> data_sram_we == 4'b0000)
        else begin
            fail_count++;
            $error("store write enabled while a syscall sits in mem");
        end

    a_commit_hold: assert property (@(posedge clk) disable iff (!resetn)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit_pc))
        else begin
            fail_count++;
            $error("commit dropped or changed while commit_ready was low");
        end

    a_ex_flush_pulse: assert property (@(posedge clk) disable iff (!resetn)
        ex_flush |=> !ex_flush)
        else begin
            fail_count++;
            $error("ex_flush high for more than one cycle");
        end

    a_ertn_flush_pulse: assert property (@(posedge clk) disable iff (!resetn)
        ertn_flush |=> !ertn_flush)
        else begin
            fail_count++;
            $error("ertn_flush high for more than one cycle");
        end

endmodule

bind lsu_top lsu_asserts u_asserts (
    .clk          (clk),
    .resetn       (resetn),
    .mem_ex       (mem_ex),
    .data_sram_we (data_sram_we),
    .commit_valid (commit_valid),
    .commit_ready (commit_ready),
    .commit_pc    (commit_pc),
    .ex_flush     (ex_flush),
    .ertn_flush   (ertn_flush)
);

//--- logic/lsu_top.sv
module lsu_top import lsu_pkg::*; #(
    parameter int sram_depth = 256,
    parameter int csr_count  = 8
) (
    input  logic        clk,
    input  logic        resetn,

    input  logic        issue_valid,
    input  issue_word_u issue_word,
    input  logic [31:0] issue_pc,
    input  logic [31:0] issue_inst,
    input  logic [31:0] rj_value,
    input  logic [31:0] rkd_value,
    input  logic [31:0] csr_wmask,
    output logic        issue_allowin,

    output logic        fwd_valid,
    output logic [4:0]  fwd_dest,
    output logic [31:0] fwd_data,
    output logic        fwd_csr,
    output logic [13:0] fwd_csr_num,

    output logic        commit_valid,
    output logic        rf_we,
    output logic [4:0]  rf_waddr,
    output logic [31:0] rf_wdata,
    output logic [31:0] commit_pc,
    input  logic        commit_ready,

    output logic        ex_flush,
    output logic [31:0] ex_era,
    output logic        ertn_flush,
    output logic [31:0] ertn_era
);

    logic        ex_mem_valid;
    logic        ex_gr_we;
    logic        ex_res_from_mem;
    logic [2:0]  ex_mem_type;
    logic [1:0]  ex_addr_low2;
    logic [4:0]  ex_dest;
    logic [31:0] ex_pc;
    logic [31:0] ex_inst;
    logic [31:0] ex_alu_result;
    logic        ex_csr_we;
    logic        ex_csr_re;
    logic [13:0] ex_csr_num;
    logic [31:0] ex_csr_wmask;
    logic [31:0] ex_csr_wvalue;
    logic        ex_ertn;
    logic        ex_syscall;

    logic        mem_allowin;
    logic        mem_wb_valid;
    logic        mem_gr_we;
    logic [4:0]  mem_dest;
    logic [31:0] mem_pc;
    logic [31:0] mem_inst;
    logic [31:0] mem_final_result;
    logic        mem_csr_we;
    logic        mem_csr_re;
    logic [13:0] mem_csr_num;
    logic [31:0] mem_csr_wmask;
    logic [31:0] mem_csr_wvalue;
    logic        mem_ertn;
    logic        mem_syscall;
    logic        mem_ex;

    logic        wb_allowin;
    logic        wb_ex;
    logic        flush_all;

    logic                          data_sram_en;
    logic [3:0]                    data_sram_we;
    logic [$clog2(sram_depth)-1:0] data_sram_addr;
    logic [31:0]                   data_sram_wdata;
    logic [31:0]                   data_sram_rdata;

    assign flush_all = wb_ex | ertn_flush; // both kill mem as well as ex

    ex_stage #(.sram_depth(sram_depth)) u_ex (
        .clk, .resetn,
        .issue_valid, .issue_word, .issue_pc, .issue_inst,
        .rj_value, .rkd_value, .csr_wmask, .issue_allowin,
        .mem_allowin, .mem_ex, .wb_ex, .ertn_flush,
        .ex_mem_valid, .ex_gr_we, .ex_res_from_mem, .ex_mem_type, .ex_addr_low2,
        .ex_dest, .ex_pc, .ex_inst, .ex_alu_result,
        .ex_csr_we, .ex_csr_re, .ex_csr_num, .ex_csr_wmask, .ex_csr_wvalue,
        .ex_ertn, .ex_syscall,
        .data_sram_en, .data_sram_we, .data_sram_addr, .data_sram_wdata
    );

    mem_stage u_mem (
        .clk, .resetn,
        .ex_mem_valid, .ex_gr_we, .ex_res_from_mem, .ex_mem_type, .ex_addr_low2,
        .ex_dest, .ex_pc, .ex_inst, .ex_alu_result,
        .ex_csr_we, .ex_csr_re, .ex_csr_num, .ex_csr_wmask, .ex_csr_wvalue,
        .ex_ertn, .ex_syscall,
        .data_sram_rdata, .wb_allowin, .wb_ex(flush_all), .mem_allowin,
        .mem_wb_valid, .mem_gr_we, .mem_dest, .mem_pc, .mem_inst, .mem_final_result,
        .mem_csr_we, .mem_csr_re, .mem_csr_num, .mem_csr_wmask, .mem_csr_wvalue,
        .mem_ertn, .mem_syscall,
        .fwd_valid, .fwd_dest, .fwd_data, .fwd_csr, .fwd_csr_num, .mem_ex
    );

    wb_stage #(.csr_count(csr_count)) u_wb (
        .clk, .resetn,
        .mem_wb_valid, .mem_gr_we, .mem_dest, .mem_pc, .mem_inst, .mem_final_result,
        .mem_csr_we, .mem_csr_re, .mem_csr_num, .mem_csr_wmask, .mem_csr_wvalue,
        .mem_ertn, .mem_syscall, .commit_ready,
        .wb_allowin, .wb_ex, .ertn_flush, .ex_flush, .ex_era, .ertn_era,
        .commit_valid, .rf_we, .rf_waddr, .rf_wdata, .commit_pc
    );

    data_sram #(.sram_depth(sram_depth)) u_sram (
        .clk,
        .en    (data_sram_en),
        .we    (data_sram_we),
        .addr  (data_sram_addr),
        .wdata (data_sram_wdata),
        .rdata (data_sram_rdata)
    );

endmodule

//--- logic/wb_stage.sv
module wb_stage import lsu_pkg::*; #(
    parameter int csr_count = 8
) (
    input  logic        clk,
    input  logic        resetn,

    input  logic        mem_wb_valid,
    input  logic        mem_gr_we,
    input  logic [4:0]  mem_dest,
    input  logic [31:0] mem_pc,
    input  logic [31:0] mem_inst,
    input  logic [31:0] mem_final_result,
    input  logic        mem_csr_we,
    input  logic        mem_csr_re,
    input  logic [13:0] mem_csr_num,
    input  logic [31:0] mem_csr_wmask,
    input  logic [31:0] mem_csr_wvalue,
    input  logic        mem_ertn,
    input  logic        mem_syscall,
    input  logic        commit_ready,

    output logic        wb_allowin,
    output logic        wb_ex,
    output logic        ertn_flush,
    output logic        ex_flush,
    output logic [31:0] ex_era,
    output logic [31:0] ertn_era,
    output logic        commit_valid,
    output logic        rf_we,
    output logic [4:0]  rf_waddr,
    output logic [31:0] rf_wdata,
    output logic [31:0] commit_pc
);

    localparam int cw = (csr_count > 1) ? $clog2(csr_count) : 1;
    localparam logic [cw-1:0] era_idx   = cw'(csr_era_slot % csr_count);
    localparam logic [cw-1:0] tinst_idx = cw'(csr_tinst_slot % csr_count);

    logic          wb_valid;
    logic          wb_gr_we;
    logic [31:0]   wb_inst;
    logic [31:0]   wb_result;
    logic          wb_csr_we;
    logic          wb_csr_re;
    logic [13:0]   wb_csr_num;
    logic [31:0]   wb_csr_wmask;
    logic [31:0]   wb_csr_wvalue;
    logic          wb_ertn;
    logic          wb_syscall;
    logic          fire;
    logic [cw-1:0] csr_idx;
    logic [31:0]   csr_regs [csr_count];

    assign fire       = wb_valid & commit_ready;
    assign wb_allowin = ~wb_valid | commit_ready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (wb_allowin) begin
            wb_valid <= mem_wb_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wb_valid && wb_allowin) begin
            wb_gr_we      <= mem_gr_we;
            rf_waddr      <= mem_dest;
            commit_pc     <= mem_pc;
            wb_inst       <= mem_inst;
            wb_result     <= mem_final_result;
            wb_csr_we     <= mem_csr_we;
            wb_csr_re     <= mem_csr_re;
            wb_csr_num    <= mem_csr_num;
            wb_csr_wmask  <= mem_csr_wmask;
            wb_csr_wvalue <= mem_csr_wvalue;
            wb_ertn       <= mem_ertn;
            wb_syscall    <= mem_syscall;
        end
    end

    assign csr_idx = cw'(wb_csr_num % 14'(csr_count)); // unimplemented numbers wrap

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < csr_count; i++) begin
                csr_regs[i] <= 32'd0;
            end
        end else if (fire) begin
            if (wb_csr_we) begin
                csr_regs[csr_idx] <= (csr_regs[csr_idx] & ~wb_csr_wmask) |
                                     (wb_csr_wvalue & wb_csr_wmask);
            end
            if (wb_syscall) begin
                csr_regs[era_idx]   <= commit_pc;
                csr_regs[tinst_idx] <= wb_inst;
            end
        end
    end

    assign commit_valid = wb_valid;
    assign rf_we        = wb_valid & wb_gr_we;
    assign rf_wdata     = wb_csr_re ? csr_regs[csr_idx] : wb_result; // old csr value

    assign wb_ex      = fire & wb_syscall;
    assign ex_flush   = wb_ex;
    assign ex_era     = commit_pc;
    assign ertn_flush = fire & wb_ertn;
    assign ertn_era   = csr_regs[era_idx];

endmodule

//--- logic/mem_stage.sv
module mem_stage import lsu_pkg::*; (
    input  logic        clk,
    input  logic        resetn,

    input  logic        ex_mem_valid,
    input  logic        ex_gr_we,
    input  logic        ex_res_from_mem,
    input  logic [2:0]  ex_mem_type,
    input  logic [1:0]  ex_addr_low2,
    input  logic [4:0]  ex_dest,
    input  logic [31:0] ex_pc,
    input  logic [31:0] ex_inst,
    input  logic [31:0] ex_alu_result,
    input  logic        ex_csr_we,
    input  logic        ex_csr_re,
    input  logic [13:0] ex_csr_num,
    input  logic [31:0] ex_csr_wmask,
    input  logic [31:0] ex_csr_wvalue,
    input  logic        ex_ertn,
    input  logic        ex_syscall,

    input  logic [31:0] data_sram_rdata,
    input  logic        wb_allowin,
    input  logic        wb_ex,
    output logic        mem_allowin,

    output logic        mem_wb_valid,
    output logic        mem_gr_we,
    output logic [4:0]  mem_dest,
    output logic [31:0] mem_pc,
    output logic [31:0] mem_inst,
    output logic [31:0] mem_final_result,
    output logic        mem_csr_we,
    output logic        mem_csr_re,
    output logic [13:0] mem_csr_num,
    output logic [31:0] mem_csr_wmask,
    output logic [31:0] mem_csr_wvalue,
    output logic        mem_ertn,
    output logic        mem_syscall,

    output logic        fwd_valid,
    output logic [4:0]  fwd_dest,
    output logic [31:0] fwd_data,
    output logic        fwd_csr,
    output logic [13:0] fwd_csr_num,
    output logic        mem_ex
);

    logic        mem_valid;
    logic        mem_res_from_mem;
    logic [2:0]  mem_type;
    logic [1:0]  mem_addr_low2;
    logic [31:0] mem_alu_result;
    logic [15:0] half_data;
    logic [7:0]  byte_data;
    logic [31:0] load_data;

    assign mem_wb_valid = mem_valid & ~wb_ex;
    assign mem_allowin  = ~mem_valid | (mem_wb_valid & wb_allowin);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_valid <= 1'b0;
        end else if (wb_ex) begin
            mem_valid <= 1'b0;
        end else if (mem_allowin) begin
            mem_valid <= ex_mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_mem_valid && mem_allowin) begin
            mem_gr_we        <= ex_gr_we;
            mem_res_from_mem <= ex_res_from_mem;
            mem_type         <= ex_mem_type;
            mem_addr_low2    <= ex_addr_low2;
            mem_dest         <= ex_dest;
            mem_pc           <= ex_pc;
            mem_inst         <= ex_inst;
            mem_alu_result   <= ex_alu_result;
            mem_csr_we       <= ex_csr_we;
            mem_csr_re       <= ex_csr_re;
            mem_csr_num      <= ex_csr_num;
            mem_csr_wmask    <= ex_csr_wmask;
            mem_csr_wvalue   <= ex_csr_wvalue;
            mem_ertn         <= ex_ertn;
            mem_syscall      <= ex_syscall;
        end
    end

    // rdata holds while the stage stalls, no new read is started
    assign half_data = mem_addr_low2[1] ? data_sram_rdata[31:16] : data_sram_rdata[15:0];
    assign byte_data = data_sram_rdata[{mem_addr_low2, 3'b000} +: 8];

    always_comb begin
        case (mem_type)
            mt_ld_w:  load_data = data_sram_rdata;
            mt_ld_h:  load_data = {{16{half_data[15]}}, half_data};
            mt_ld_hu: load_data = {16'd0, half_data};
            mt_ld_b:  load_data = {{24{byte_data[7]}}, byte_data};
            mt_ld_bu: load_data = {24'd0, byte_data};
            default:  load_data = data_sram_rdata;
        endcase
    end

    assign mem_final_result = mem_res_from_mem ? load_data : mem_alu_result;

    assign fwd_valid   = mem_valid & mem_gr_we;
    assign fwd_dest    = mem_dest;
    assign fwd_data    = mem_final_result;
    assign fwd_csr     = mem_valid & (mem_csr_we | mem_csr_re); // decode must wait on these
    assign fwd_csr_num = mem_csr_num;
    assign mem_ex      = mem_valid & mem_syscall;

endmodule

//--- logic/ex_stage.sv
module ex_stage import lsu_pkg::*; #(
    parameter int sram_depth = 256
) (
    input  logic                          clk,
    input  logic                          resetn,

    input  logic                          issue_valid,
    input  issue_word_u                   issue_word,
    input  logic [31:0]                   issue_pc,
    input  logic [31:0]                   issue_inst,
    input  logic [31:0]                   rj_value,
    input  logic [31:0]                   rkd_value,
    input  logic [31:0]                   csr_wmask,
    output logic                          issue_allowin,

    input  logic                          mem_allowin,
    input  logic                          mem_ex,
    input  logic                          wb_ex,
    input  logic                          ertn_flush,

    output logic                          ex_mem_valid,
    output logic                          ex_gr_we,
    output logic                          ex_res_from_mem,
    output logic [2:0]                    ex_mem_type,
    output logic [1:0]                    ex_addr_low2,
    output logic [4:0]                    ex_dest,
    output logic [31:0]                   ex_pc,
    output logic [31:0]                   ex_inst,
    output logic [31:0]                   ex_alu_result,
    output logic                          ex_csr_we,
    output logic                          ex_csr_re,
    output logic [13:0]                   ex_csr_num,
    output logic [31:0]                   ex_csr_wmask,
    output logic [31:0]                   ex_csr_wvalue,
    output logic                          ex_ertn,
    output logic                          ex_syscall,

    output logic                          data_sram_en,
    output logic [3:0]                    data_sram_we,
    output logic [$clog2(sram_depth)-1:0] data_sram_addr,
    output logic [31:0]                   data_sram_wdata
);

    localparam int aw = $clog2(sram_depth);

    logic        ex_valid;
    issue_word_u ex_word;
    logic [31:0] ex_rj;
    logic [31:0] ex_rkd;
    op_class_e   ex_class;
    logic        flush;
    logic        leave;
    logic        is_load;
    logic        is_store;
    logic        is_csr;
    logic        st_kill;
    logic [31:0] ex_addr;
    logic [3:0]  st_be;

    assign flush         = wb_ex | ertn_flush;
    assign ex_mem_valid  = ex_valid & ~flush;
    assign leave         = ex_mem_valid & mem_allowin;
    assign issue_allowin = ~flush & (~ex_valid | mem_allowin);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid <= 1'b0;
        end else if (flush) begin
            ex_valid <= 1'b0;
        end else if (issue_allowin) begin
            ex_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid && issue_allowin) begin
            ex_word      <= issue_word;
            ex_pc        <= issue_pc;
            ex_inst      <= issue_inst;
            ex_rj        <= rj_value;
            ex_rkd       <= rkd_value;
            ex_csr_wmask <= csr_wmask;
        end
    end

    // op_class sits in the same bits of both views
    assign ex_class = ex_word.mem_op.op_class;
    assign is_load  = ex_class == op_load;
    assign is_store = ex_class == op_store;
    assign is_csr   = ex_class == op_csr;

    assign ex_syscall      = ex_class == op_syscall;
    assign ex_ertn         = ex_class == op_ertn;
    assign ex_csr_we       = is_csr & ex_word.csr_op.csr_we;
    assign ex_csr_re       = is_csr & ex_word.csr_op.csr_re;
    assign ex_csr_num      = is_csr ? ex_word.csr_op.csr_num : 14'd0;
    assign ex_csr_wvalue   = ex_rkd;
    assign ex_dest         = is_csr ? ex_word.csr_op.dest : ex_word.mem_op.dest;
    assign ex_mem_type     = (is_load | is_store) ? ex_word.mem_op.mem_type : 3'd0;
    assign ex_gr_we        = (ex_class == op_alu) | is_load | ex_csr_re;
    assign ex_res_from_mem = is_load;

    assign ex_addr      = ex_rj + {{20{ex_word.mem_op.offset[11]}}, ex_word.mem_op.offset};
    assign ex_addr_low2 = ex_addr[1:0];
    assign ex_alu_result = (is_load | is_store)  ? ex_addr :
                           (ex_class == op_alu) ? ex_rj   : 32'd0;

    // lanes replicated, enables pick the bytes
    always_comb begin
        case (ex_mem_type[1:0])
            sz_word: begin
                st_be           = 4'b1111;
                data_sram_wdata = ex_rkd;
            end
            sz_half: begin
                st_be           = ex_addr[1] ? 4'b1100 : 4'b0011;
                data_sram_wdata = {2{ex_rkd[15:0]}};
            end
            sz_byte: begin
                st_be           = 4'b0001 << ex_addr[1:0];
                data_sram_wdata = {4{ex_rkd[7:0]}};
            end
            default: begin
                st_be           = 4'b0000;
                data_sram_wdata = ex_rkd;
            end
        endcase
    end

    assign st_kill        = mem_ex | wb_ex | ertn_flush | ex_syscall;
    assign data_sram_en   = leave & (is_load | (is_store & ~st_kill));
    assign data_sram_we   = (leave & is_store & ~st_kill) ? st_be : 4'b0000;
    assign data_sram_addr = ex_addr[aw+1:2]; // misaligned bits dropped

endmodule

//--- logic/data_sram.sv
module data_sram #(
    parameter int sram_depth = 256
) (
    input  logic                          clk,
    input  logic                          en,
    input  logic [3:0]                    we,
    input  logic [$clog2(sram_depth)-1:0] addr,
    input  logic [31:0]                   wdata,
    output logic [31:0]                   rdata
);

    logic [31:0] mem [sram_depth];

    initial begin
        for (int i = 0; i < sram_depth; i++) begin
            mem[i] = 32'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            for (int b = 0; b < 4; b++) begin
                if (we[b]) begin
                    mem[addr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
            rdata <= mem[addr]; // old word on a write cycle
        end
    end

endmodule

//--- logic/lsu_pkg.sv
package lsu_pkg;

    typedef enum logic [2:0] {
        op_alu     = 3'd0,
        op_load    = 3'd1,
        op_store   = 3'd2,
        op_csr     = 3'd3,
        op_syscall = 3'd4,
        op_ertn    = 3'd5
    } op_class_e;

    // access size, low two bits of mem_type
    localparam logic [1:0] sz_word = 2'b00;
    localparam logic [1:0] sz_half = 2'b01;
    localparam logic [1:0] sz_byte = 2'b10;

    localparam logic [2:0] mt_ld_w  = 3'b000;
    localparam logic [2:0] mt_ld_h  = 3'b001;
    localparam logic [2:0] mt_ld_b  = 3'b010;
    localparam logic [2:0] mt_ld_hu = 3'b101; // top bit marks unsigned
    localparam logic [2:0] mt_ld_bu = 3'b110;

    localparam int csr_era_slot   = 6;
    localparam int csr_tinst_slot = 7; // inst word of the last syscall

    typedef struct packed {
        op_class_e          op_class;
        logic [2:0]         mem_type;
        logic [4:0]         dest;
        logic signed [11:0] offset;
        logic [8:0]         rsvd;
    } mem_view_t;

    typedef struct packed {
        op_class_e   op_class;
        logic        csr_we;
        logic        csr_re;
        logic [13:0] csr_num;
        logic [4:0]  dest;
        logic [7:0]  rsvd;
    } csr_view_t;

    typedef union packed {
        mem_view_t mem_op;
        csr_view_t csr_op;
    } issue_word_u;

endpackage
